// ==== verification/rs_tests.txt ====
// Word 0 instruction count, then 32 initial registers, then per instruction
// ctrl {use_imm[31:28], op[27:24], rs[23:16], rt[15:8], rd[7:0]} and imm, then 32 final registers
0000000c
00000000 00000001 00000002 00000003 00000004 00000005 00000006 00000007
00000008 00000009 0000000a 0000000b 0000000c 0000000d 0000000e 0000000f
00000010 00000011 00000012 00000013 00000014 00000015 00000016 00000017
00000018 00000019 0000001a 0000001b 0000001c 0000001d 0000001e 0000001f
0001020a 00000000
01050a0b 00000000
100b000c 00000100
0204050d 00000000
020d060e 00000000
0207080f 00000000
000c090a 00000000
000a0a10 00000000
010e0d11 00000000
0201020d 00000000
100d0012 ffffffff
000a010a 00000000
00000000 00000001 00000002 00000003 00000004 00000005 00000006 00000007
00000008 00000009 0000010c 00000002 00000102 00000002 00000078 00000038
00000216 00000064 00000001 00000013 00000014 00000015 00000016 00000017
00000018 00000019 0000001a 0000001b 0000001c 0000001d 0000001e 0000001f

// ==== sim.f ====
logic/rs_pkg.sv
logic/issue_decode.sv
logic/station_execute.sv
logic/tag_result.sv
logic/reservation_station.sv
verification/reservation_station_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= reservation_station_tb
FLIST     ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/reservation_station_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module reservation_station_tb;
    import rs_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int MEM_WORDS  = 256;
    localparam int MAX_INS    = 64;

    logic               clk;
    logic               reset;
    issue_t             issue;
    cdb_t               cdb;
    logic [REG_ADDR_W-1:0] read_addr1;
    logic [REG_ADDR_W-1:0] read_addr2;
    logic [DATA_W-1:0]  read_data1;
    logic [DATA_W-1:0]  read_data2;
    logic               stall;
    dispatch_t          add_disp [NUM_ADD];
    dispatch_t          mul_disp [NUM_MUL];
    reg_write_t         reg_write;
    logic               done;

    logic [31:0]       mem [0:MEM_WORDS-1];
    logic [DATA_W-1:0] regfile [NUM_REGS];
    logic [DATA_W-1:0] exp_final [NUM_REGS];
    logic [DATA_W-1:0] latest_val [NUM_REGS];
    issue_t            ins [MAX_INS];
    logic [DATA_W-1:0] exp_a [MAX_INS];
    logic [DATA_W-1:0] exp_b [MAX_INS];
    logic [DATA_W-1:0] exp_res [MAX_INS];
    int                tag_owner [16];
    bit                tag_live [16];
    bit                started [16];
    bit                add_busy_m [NUM_ADD];
    bit                mul_busy_m [NUM_MUL];
    tag_t              pend_tag [$];
    logic [DATA_W-1:0] pend_data [$];
    int                pend_rel [$];

    logic [31:0] lfsr;
    int          num_ins;
    int          next_ins;
    int          cycle;
    int          limit;
    int          free_cycle;
    int          errors;
    int          checks;
    bit          accept;
    bit          finished;
    bit          timed_out;
    bit          wb_pending;
    logic [REG_ADDR_W-1:0] wb_addr;
    logic [DATA_W-1:0]     wb_data;

    assign read_data1 = regfile[read_addr1];
    assign read_data2 = regfile[read_addr2];

    reservation_station #(
        .NUM_ADD (NUM_ADD),
        .NUM_MUL (NUM_MUL)
    ) i_reservation_station (
        .clk          (clk),
        .reset        (reset),
        .issue        (issue),
        .read_addr1   (read_addr1),
        .read_addr2   (read_addr2),
        .read_data1   (read_data1),
        .read_data2   (read_data2),
        .cdb          (cdb),
        .stall        (stall),
        .add_dispatch (add_disp),
        .mul_dispatch (mul_disp),
        .reg_write    (reg_write),
        .done         (done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    function automatic int take_bit();
        lfsr = lfsr_next(lfsr);
        return int'(lfsr[0]);
    endfunction

    // Product keeps the low 32 bits
    function automatic logic [DATA_W-1:0] fu_result(input op_t op, input logic [DATA_W-1:0] a,
                                                    input logic [DATA_W-1:0] b);
        case (op)
            OP_SUB:  return a - b;
            OP_MUL:  return a * b;
            default: return a + b;
        endcase
    endfunction

    task automatic report_error(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        errors++;
    endtask

    function automatic bit bank_full(input bit is_mul);
        bit full;
        full = 1'b1;
        if (is_mul) begin
            foreach (mul_busy_m[i]) full &= mul_busy_m[i];
        end else begin
            foreach (add_busy_m[i]) full &= add_busy_m[i];
        end
        return full;
    endfunction

    function automatic bit bank_empty();
        bit empty;
        empty = 1'b1;
        foreach (add_busy_m[i]) empty &= !add_busy_m[i];
        foreach (mul_busy_m[i]) empty &= !mul_busy_m[i];
        return empty;
    endfunction

    task automatic load_tests();
        logic [DATA_W-1:0] seq [NUM_REGS];
        logic [31:0]       ctrl;
        $readmemh("verification/rs_tests.txt", mem);
        num_ins = int'(mem[0]);
        if (num_ins <= 0 || num_ins > MAX_INS) begin
            $display("Could not read a valid instruction count from the test file");
            num_ins = 0;
            errors++;
        end
        for (int r = 0; r < NUM_REGS; r++) begin
            seq[r]        = mem[1 + r];
            regfile[r]    = mem[1 + r];
            latest_val[r] = mem[1 + r];
            exp_final[r]  = mem[33 + 2 * num_ins + r];
        end
        // In-order execution gives each instruction its operands and result
        for (int k = 0; k < num_ins; k++) begin
            ctrl            = mem[33 + 2 * k];
            ins[k].valid    = 1'b1;
            ins[k].op       = op_t'(ctrl[25:24]);
            ins[k].rs       = ctrl[20:16];
            ins[k].rt       = ctrl[12:8];
            ins[k].rd       = ctrl[4:0];
            ins[k].use_imm  = ctrl[28];
            ins[k].imm      = mem[34 + 2 * k];
            exp_a[k]        = seq[ins[k].rs];
            exp_b[k]        = (ins[k].use_imm && ins[k].op != OP_MUL) ? ins[k].imm
                                                                      : seq[ins[k].rt];
            exp_res[k]      = fu_result(ins[k].op, exp_a[k], exp_b[k]);
            seq[ins[k].rd]  = exp_res[k];
        end
    endtask

    task automatic check_start(input dispatch_t d);
        int k;
        int lat;
        checks++;
        if (!tag_live[d.tag] || started[d.tag]) begin
            report_error($sformatf("start on tag %0d with no waiting instruction", d.tag));
        end else begin
            k = tag_owner[d.tag];
            started[d.tag] = 1'b1;
            if (d.op != ins[k].op || d.src_a != exp_a[k] || d.src_b != exp_b[k]) begin
                report_error($sformatf("instr %0d tag %0d launched op %0d a %h b %h",
                                       k, d.tag, d.op, d.src_a, d.src_b));
            end
            lat = 2 + take_bit();
            lat = lat + 2 * take_bit();
            pend_tag.push_back(d.tag);
            pend_data.push_back(fu_result(d.op, d.src_a, d.src_b));
            pend_rel.push_back(cycle + lat);
        end
    endtask

    // Samples the DUT mid-cycle and steps the models to the next edge
    task automatic observe_cycle();
        bit   is_mul;
        bit   found;
        bit   drained;
        tag_t tag;
        foreach (add_disp[i]) if (add_disp[i].start) check_start(add_disp[i]);
        foreach (mul_disp[i]) if (mul_disp[i].start) check_start(mul_disp[i]);
        if (reg_write.valid) begin
            checks++;
            if (reg_write.data != latest_val[reg_write.addr]) begin
                report_error($sformatf("r%0d written with %h, latest writer gives %h",
                                       reg_write.addr, reg_write.data,
                                       latest_val[reg_write.addr]));
            end
            wb_pending = 1'b1;
            wb_addr    = reg_write.addr;
            wb_data    = reg_write.data;
        end
        drained = next_ins == num_ins && bank_empty() && pend_tag.size() == 0;
        if (done) begin
            checks++;
            if (!drained || cycle != free_cycle + 2) begin
                report_error($sformatf("done high in cycle %0d, expected %0d after drain",
                                       cycle, free_cycle + 2));
            end
            finished = 1'b1;
        end
        accept = 1'b0;
        if (issue.valid) begin
            is_mul = issue.op == OP_MUL;
            checks++;
            if (stall != bank_full(is_mul)) begin
                report_error($sformatf("stall is %0b for instr %0d", stall, next_ins));
            end
            accept = !stall;
        end
        if (accept) begin
            found = 1'b0;
            tag   = '0;
            if (is_mul) begin
                for (int i = 0; i < NUM_MUL && !found; i++) begin
                    if (!mul_busy_m[i]) begin
                        mul_busy_m[i] = 1'b1;
                        tag   = tag_t'(MUL_TAG_BASE + i);
                        found = 1'b1;
                    end
                end
            end else begin
                for (int i = 0; i < NUM_ADD && !found; i++) begin
                    if (!add_busy_m[i]) begin
                        add_busy_m[i] = 1'b1;
                        tag   = tag_t'(ADD_TAG_BASE + i);
                        found = 1'b1;
                    end
                end
            end
            if (!found) begin
                report_error($sformatf("instr %0d accepted into a full bank", next_ins));
            end
            tag_owner[tag] = next_ins;
            tag_live[tag]  = 1'b1;
            started[tag]   = 1'b0;
            latest_val[issue.rd] = exp_res[next_ins];
            next_ins++;
        end
        if (cdb.valid) begin
            tag_live[cdb.tag] = 1'b0;
            if (cdb.tag >= tag_t'(MUL_TAG_BASE)) begin
                mul_busy_m[int'(cdb.tag) - MUL_TAG_BASE] = 1'b0;
            end else begin
                add_busy_m[int'(cdb.tag) - ADD_TAG_BASE] = 1'b0;
            end
            if (next_ins == num_ins && bank_empty()) begin
                free_cycle = cycle;
            end
        end
    endtask

    task automatic drive_inputs();
        bit sent;
        if (wb_pending) begin
            regfile[wb_addr] = wb_data;
            wb_pending = 1'b0;
        end
        if (accept) begin
            issue = (next_ins < num_ins) ? ins[next_ins] : '0;
        end
        // Oldest released result takes the bus
        sent = 1'b0;
        cdb  = '0;
        for (int j = 0; j < pend_tag.size() && !sent; j++) begin
            if (pend_rel[j] <= cycle) begin
                cdb = '{valid: 1'b1, tag: pend_tag[j], data: pend_data[j]};
                pend_tag.delete(j);
                pend_data.delete(j);
                pend_rel.delete(j);
                sent = 1'b1;
            end
        end
    endtask

    initial begin
        errors     = 0;
        checks     = 0;
        cycle      = 0;
        next_ins   = 0;
        free_cycle = -10;
        lfsr       = 32'h6eb5_9d10;
        accept     = 1'b0;
        finished   = 1'b0;
        timed_out  = 1'b0;
        wb_pending = 1'b0;
        issue      = '0;
        cdb        = '0;
        reset      = 1'b1;
        foreach (tag_live[i]) tag_live[i] = 1'b0;
        foreach (started[i]) started[i] = 1'b0;
        foreach (add_busy_m[i]) add_busy_m[i] = 1'b0;
        foreach (mul_busy_m[i]) mul_busy_m[i] = 1'b0;
        load_tests();
        limit = 60 * num_ins + 200;
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;
        if (num_ins > 0) begin
            issue = ins[0];
        end
        while (!finished && !timed_out) begin
            @(negedge clk);
            cycle++;
            observe_cycle();
            if (cycle > limit) begin
                timed_out = 1'b1;
            end else if (!finished) begin
                @(posedge clk);
                #2;
                drive_inputs();
            end
        end
        if (timed_out) begin
            $display("Timeout: the run did not drain within %0d cycles", limit);
        end else begin
            for (int r = 0; r < NUM_REGS; r++) begin
                checks++;
                if (regfile[r] !== exp_final[r]) begin
                    report_error($sformatf("r%0d is %h, expected %h",
                                           r, regfile[r], exp_final[r]));
                end
            end
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/reservation_station.sv ====
`timescale 1ns/1ps
`default_nettype none

module reservation_station #(
    parameter int NUM_ADD = rs_pkg::NUM_ADD,
    parameter int NUM_MUL = rs_pkg::NUM_MUL
) (
    input  logic                          clk,
    input  logic                          reset,
    input  rs_pkg::issue_t                issue,
    output logic [rs_pkg::REG_ADDR_W-1:0] read_addr1,
    output logic [rs_pkg::REG_ADDR_W-1:0] read_addr2,
    input  logic [rs_pkg::DATA_W-1:0]     read_data1,
    input  logic [rs_pkg::DATA_W-1:0]     read_data2,
    input  rs_pkg::cdb_t                  cdb,
    output logic                          stall,
    output rs_pkg::dispatch_t             add_dispatch [NUM_ADD],
    output rs_pkg::dispatch_t             mul_dispatch [NUM_MUL],
    output rs_pkg::reg_write_t            reg_write,
    output logic                          done
);
    import rs_pkg::*;

    alloc_t             add_alloc;
    alloc_t             mul_alloc;
    rename_t            rename;
    tag_t               qj;
    tag_t               qk;
    logic [NUM_ADD-1:0] add_busy;
    logic [NUM_MUL-1:0] mul_busy;
    logic               any_busy;

    assign any_busy = (|add_busy) | (|mul_busy);

    issue_decode #(
        .NUM_ADD (NUM_ADD),
        .NUM_MUL (NUM_MUL)
    ) i_issue_decode (
        .issue      (issue),
        .read_data1 (read_data1),
        .read_data2 (read_data2),
        .qj         (qj),
        .qk         (qk),
        .reg_write  (reg_write),
        .add_busy   (add_busy),
        .mul_busy   (mul_busy),
        .read_addr1 (read_addr1),
        .read_addr2 (read_addr2),
        .add_alloc  (add_alloc),
        .mul_alloc  (mul_alloc),
        .rename     (rename),
        .stall      (stall)
    );

    // Adder bank takes tags from 1, multiplier bank from 4
    station_execute #(
        .NUM_ENTRIES (NUM_ADD),
        .TAG_BASE    (ADD_TAG_BASE),
        .ALLOW_SUB   (1'b1)
    ) i_add_bank (
        .clk      (clk),
        .reset    (reset),
        .alloc    (add_alloc),
        .cdb      (cdb),
        .busy     (add_busy),
        .dispatch (add_dispatch)
    );

    station_execute #(
        .NUM_ENTRIES (NUM_MUL),
        .TAG_BASE    (MUL_TAG_BASE),
        .ALLOW_SUB   (1'b0)
    ) i_mul_bank (
        .clk      (clk),
        .reset    (reset),
        .alloc    (mul_alloc),
        .cdb      (cdb),
        .busy     (mul_busy),
        .dispatch (mul_dispatch)
    );

    tag_result i_tag_result (
        .clk       (clk),
        .reset     (reset),
        .issue_rs  (issue.rs),
        .issue_rt  (issue.rt),
        .rename    (rename),
        .cdb       (cdb),
        .any_busy  (any_busy),
        .qj        (qj),
        .qk        (qk),
        .reg_write (reg_write),
        .done      (done)
    );

endmodule

`default_nettype wire

// ==== logic/tag_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module tag_result (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [rs_pkg::REG_ADDR_W-1:0] issue_rs,
    input  logic [rs_pkg::REG_ADDR_W-1:0] issue_rt,
    input  rs_pkg::rename_t               rename,
    input  rs_pkg::cdb_t                  cdb,
    input  logic                          any_busy,
    output rs_pkg::tag_t                  qj,
    output rs_pkg::tag_t                  qk,
    output rs_pkg::reg_write_t            reg_write,
    output logic                          done
);
    import rs_pkg::*;

    tag_t                  status [NUM_REGS];
    logic [NUM_REGS-1:0]   retire;
    logic                  cdb_hit;
    logic [REG_ADDR_W-1:0] cdb_addr;
    logic                  wb_valid;
    logic [REG_ADDR_W-1:0] wb_addr;
    logic [DATA_W-1:0]     wb_data;
    logic                  was_busy;

    assign qj = status[issue_rs];
    assign qk = status[issue_rt];

    // Same-cycle rename of the register beats the retiring tag
    always_comb begin
        cdb_hit  = 1'b0;
        cdb_addr = '0;
        for (int r = 0; r < NUM_REGS; r++) begin
            retire[r] = cdb.valid && cdb.tag != '0 && status[r] == cdb.tag
                        && !(rename.valid && rename.rd == REG_ADDR_W'(r));
            if (retire[r]) begin
                cdb_hit  = 1'b1;
                cdb_addr = REG_ADDR_W'(r);
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                status[r] <= '0;
            end
            wb_valid <= 1'b0;
            was_busy <= 1'b0;
            done     <= 1'b0;
        end else begin
            for (int r = 0; r < NUM_REGS; r++) begin
                if (rename.valid && rename.rd == REG_ADDR_W'(r)) begin
                    status[r] <= rename.tag;
                end else if (retire[r]) begin
                    status[r] <= '0;
                end
            end
            wb_valid <= cdb_hit;
            was_busy <= was_busy | any_busy;
            done     <= was_busy && !any_busy && !rename.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (cdb_hit) begin
            wb_addr <= cdb_addr;
            wb_data <= cdb.data;
        end
    end

    assign reg_write = '{valid: wb_valid, addr: wb_addr, data: wb_data};

endmodule

`default_nettype wire

// ==== logic/station_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module station_execute #(
    parameter int NUM_ENTRIES = rs_pkg::NUM_ADD,
    parameter int TAG_BASE    = rs_pkg::ADD_TAG_BASE,
    parameter bit ALLOW_SUB   = 1'b1
) (
    input  logic                   clk,
    input  logic                   reset,
    input  rs_pkg::alloc_t         alloc,
    input  rs_pkg::cdb_t           cdb,
    output logic [NUM_ENTRIES-1:0] busy,
    output rs_pkg::dispatch_t      dispatch [NUM_ENTRIES]
);
    import rs_pkg::*;

    typedef struct packed {
        op_t      op;
        operand_t a;
        operand_t b;
    } entry_t;

    entry_t                 entry [NUM_ENTRIES];
    logic [NUM_ENTRIES-1:0] fired;
    logic [NUM_ENTRIES-1:0] ready;
    logic [NUM_ENTRIES-1:0] own_beat;
    logic [NUM_ENTRIES-1:0] load;
    logic [NUM_ENTRIES-1:0] start;
    op_t                    disp_op [NUM_ENTRIES];
    logic [DATA_W-1:0]      disp_a [NUM_ENTRIES];
    logic [DATA_W-1:0]      disp_b [NUM_ENTRIES];

    // Take the bus value when it carries the awaited tag
    function automatic operand_t snoop(input operand_t opd, input cdb_t beat);
        operand_t res;
        res = opd;
        if (beat.valid && opd.q != '0 && opd.q == beat.tag) begin
            res.q = '0;
            res.v = beat.data;
        end
        return res;
    endfunction

    function automatic op_t bank_op(input op_t op);
        if (!ALLOW_SUB) begin
            return OP_MUL;
        end
        return (op == OP_SUB) ? OP_SUB : OP_ADD;
    endfunction

    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            load[i]     = alloc.valid && alloc.index == tag_t'(i);
            own_beat[i] = cdb.valid && cdb.tag == tag_t'(TAG_BASE + i);
            ready[i]    = busy[i] && !fired[i]
                          && entry[i].a.q == '0 && entry[i].b.q == '0;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy  <= '0;
            fired <= '0;
            start <= '0;
        end else begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                start[i] <= ready[i];
                if (own_beat[i]) begin
                    busy[i]  <= 1'b0;
                    fired[i] <= 1'b0;
                end else if (load[i]) begin
                    busy[i]  <= 1'b1;
                    fired[i] <= 1'b0;
                end else if (ready[i]) begin
                    fired[i] <= 1'b1;
                end
            end
        end
    end

    // Operand capture and the launch payload
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (load[i]) begin
                entry[i].op <= bank_op(alloc.op);
                entry[i].a  <= snoop(alloc.a, cdb);
                entry[i].b  <= snoop(alloc.b, cdb);
            end else begin
                entry[i].a <= snoop(entry[i].a, cdb);
                entry[i].b <= snoop(entry[i].b, cdb);
            end
            if (ready[i]) begin
                disp_op[i] <= entry[i].op;
                disp_a[i]  <= entry[i].a.v;
                disp_b[i]  <= entry[i].b.v;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            dispatch[i] = '{start: start[i], op: disp_op[i],
                            tag: tag_t'(TAG_BASE + i),
                            src_a: disp_a[i], src_b: disp_b[i]};
        end
    end

endmodule

`default_nettype wire

// ==== logic/issue_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_decode #(
    parameter int NUM_ADD = rs_pkg::NUM_ADD,
    parameter int NUM_MUL = rs_pkg::NUM_MUL
) (
    input  rs_pkg::issue_t                issue,
    input  logic [rs_pkg::DATA_W-1:0]     read_data1,
    input  logic [rs_pkg::DATA_W-1:0]     read_data2,
    input  rs_pkg::tag_t                  qj,
    input  rs_pkg::tag_t                  qk,
    input  rs_pkg::reg_write_t            reg_write,
    input  logic [NUM_ADD-1:0]            add_busy,
    input  logic [NUM_MUL-1:0]            mul_busy,
    output logic [rs_pkg::REG_ADDR_W-1:0] read_addr1,
    output logic [rs_pkg::REG_ADDR_W-1:0] read_addr2,
    output rs_pkg::alloc_t                add_alloc,
    output rs_pkg::alloc_t                mul_alloc,
    output rs_pkg::rename_t               rename,
    output logic                          stall
);
    import rs_pkg::*;

    logic     is_mul;
    logic     bank_full;
    logic     take;
    tag_t     add_idx;
    tag_t     mul_idx;
    tag_t     new_tag;
    operand_t src_a;
    operand_t src_b;

    // Writeback lands in the register file one edge after the status clears,
    // so a value retiring this cycle is forwarded here
    function automatic operand_t form_operand(
        input tag_t                  q,
        input logic [REG_ADDR_W-1:0] addr,
        input logic [DATA_W-1:0]     data,
        input reg_write_t            wb
    );
        operand_t opd;
        opd.q = q;
        opd.v = data;
        if (q != '0) begin
            opd.v = '0;
        end else if (wb.valid && wb.addr == addr) begin
            opd.v = wb.data;
        end
        return opd;
    endfunction

    assign read_addr1 = issue.rs;
    assign read_addr2 = issue.rt;

    assign is_mul    = (issue.op == OP_MUL);
    assign bank_full = is_mul ? (&mul_busy) : (&add_busy);
    assign stall     = issue.valid && bank_full;
    assign take      = issue.valid && !bank_full;

    // Lowest free entry in each bank
    always_comb begin
        add_idx = '0;
        for (int i = NUM_ADD - 1; i >= 0; i--) begin
            if (!add_busy[i]) begin
                add_idx = tag_t'(i);
            end
        end
        mul_idx = '0;
        for (int i = NUM_MUL - 1; i >= 0; i--) begin
            if (!mul_busy[i]) begin
                mul_idx = tag_t'(i);
            end
        end
    end

    always_comb begin
        src_a = form_operand(qj, issue.rs, read_data1, reg_write);
        if (issue.use_imm && !is_mul) begin
            src_b = '{q: '0, v: issue.imm};
        end else begin
            src_b = form_operand(qk, issue.rt, read_data2, reg_write);
        end
    end

    assign new_tag = is_mul ? tag_t'(MUL_TAG_BASE) + mul_idx
                            : tag_t'(ADD_TAG_BASE) + add_idx;

    assign add_alloc = '{valid: take && !is_mul, index: add_idx, op: issue.op,
                         a: src_a, b: src_b};
    assign mul_alloc = '{valid: take && is_mul, index: mul_idx, op: issue.op,
                         a: src_a, b: src_b};

    assign rename = '{valid: take, rd: issue.rd, tag: new_tag};

endmodule

`default_nettype wire

// ==== logic/rs_pkg.sv ====
`default_nettype none

package rs_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int TAG_W      = 4;

    // Tag 0 means the value is already present
    typedef logic [TAG_W-1:0] tag_t;

    localparam int ADD_TAG_BASE = 1;
    localparam int MUL_TAG_BASE = 4;
    localparam int NUM_ADD      = 3;
    localparam int NUM_MUL      = 2;

    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_MUL = 2'd2
    } op_t;

    typedef struct packed {
        logic                  valid;
        op_t                   op;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd;
        logic                  use_imm;
        logic [DATA_W-1:0]     imm;
    } issue_t;

    typedef struct packed {
        tag_t              q;
        logic [DATA_W-1:0] v;
    } operand_t;

    typedef struct packed {
        logic              start;
        op_t               op;
        tag_t              tag;
        logic [DATA_W-1:0] src_a;
        logic [DATA_W-1:0] src_b;
    } dispatch_t;

    typedef struct packed {
        logic              valid;
        tag_t              tag;
        logic [DATA_W-1:0] data;
    } cdb_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] addr;
        logic [DATA_W-1:0]     data;
    } reg_write_t;

    // Entry write into one station bank
    typedef struct packed {
        logic     valid;
        tag_t     index;
        op_t      op;
        operand_t a;
        operand_t b;
    } alloc_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        tag_t                  tag;
    } rename_t;

endpackage

`default_nettype wire
